// File: attn_pkg.sv
//##########################################################################
// shared widths, types and constants of the attention datapath
// operand stores are 8x8 row-major, T is limited to 1, 4 or 8 rows
//##########################################################################

package attn_pkg;

    //######################################################################
    // sizes and schedule constants
    //######################################################################

    // feature count, also the lane count of every dot product
    localparam int D_MODEL      = 8;
    // depth of every operand and result store
    localparam int MAT_SIZE     = D_MODEL * D_MODEL;
    // load window, one X, Wq, Wk, Wv element per cycle
    localparam int LOAD_CYCLES  = 192;
    localparam int W_SEG        = 64;
    // lets the last score leave its 3-stage pipeline before S is read
    localparam int DRAIN_CYCLES = 2;
    // full Q.K sum, 38-bit products plus 3 bits of growth
    localparam int DOT_W        = 41;

    //######################################################################
    // element types
    //######################################################################

    typedef logic signed [7:0]  token_t;
    typedef logic signed [7:0]  weight_t;
    typedef logic        [3:0]  rows_t;
    typedef logic        [7:0]  idx_t;
    typedef logic signed [18:0] proj_t;
    // clamped before the divide, so never negative
    typedef logic        [36:0] score_t;
    typedef logic signed [58:0] out_t;

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        PROJ_Q,
        PROJ_K,
        PROJ_V,
        SCORE,
        DRAIN,
        OUT
    } phase_t;

endpackage

// File: attn_ctrl.sv
//##########################################################################
// phase FSM of the attention run, advanced by the step counter's last flag
// in_valid is only looked at in IDLE, T values other than 1 or 4 run as 8
//##########################################################################

`timescale 1ns/1ps

module attn_ctrl (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  attn_pkg::rows_t  t_in,
    input  logic             last,
    output attn_pkg::phase_t phase,
    output logic             start,
    output attn_pkg::rows_t  t_rows
);

    attn_pkg::phase_t phase_nxt;
    attn_pkg::rows_t  t_norm;

    // first load beat, seen while still idle
    assign start = (phase == attn_pkg::IDLE) && in_valid;

    always_comb begin
        case (t_in)
            4'd1:    t_norm = 4'd1;
            4'd4:    t_norm = 4'd4;
            default: t_norm = attn_pkg::rows_t'(attn_pkg::D_MODEL);
        endcase
    end

    always_comb begin
        phase_nxt = phase;
        case (phase)
            attn_pkg::IDLE: begin
                if (in_valid)
                    phase_nxt = attn_pkg::LOAD;
            end
            attn_pkg::LOAD:   if (last) phase_nxt = attn_pkg::PROJ_Q;
            attn_pkg::PROJ_Q: if (last) phase_nxt = attn_pkg::PROJ_K;
            attn_pkg::PROJ_K: if (last) phase_nxt = attn_pkg::PROJ_V;
            attn_pkg::PROJ_V: if (last) phase_nxt = attn_pkg::SCORE;
            attn_pkg::SCORE:  if (last) phase_nxt = attn_pkg::DRAIN;
            attn_pkg::DRAIN:  if (last) phase_nxt = attn_pkg::OUT;
            attn_pkg::OUT:    if (last) phase_nxt = attn_pkg::IDLE;
            default:          phase_nxt = attn_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= attn_pkg::IDLE;
        end else begin
            phase <= phase_nxt;
        end
    end

    // T is held for the whole run
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            t_rows <= attn_pkg::rows_t'(attn_pkg::D_MODEL);
        end else if (start) begin
            t_rows <= t_norm;
        end
    end

endmodule

// File: attn_step_counter.sv
//##########################################################################
// step index inside the current phase, cleared on every phase change
// the start beat counts as step 0 of the load window
//##########################################################################

`timescale 1ns/1ps

module attn_step_counter (
    input  logic             clk,
    input  logic             rst_n,
    input  attn_pkg::phase_t phase,
    input  logic             start,
    input  attn_pkg::rows_t  t_rows,
    output attn_pkg::idx_t   idx,
    output logic             last
);

    attn_pkg::idx_t len;

    // phase length in cycles
    always_comb begin
        case (phase)
            attn_pkg::PROJ_Q, attn_pkg::PROJ_K, attn_pkg::PROJ_V, attn_pkg::OUT:
                len = attn_pkg::idx_t'(t_rows) * attn_pkg::idx_t'(attn_pkg::D_MODEL);
            attn_pkg::SCORE: len = attn_pkg::idx_t'(t_rows) * attn_pkg::idx_t'(t_rows);
            attn_pkg::DRAIN: len = attn_pkg::idx_t'(attn_pkg::DRAIN_CYCLES);
            default:         len = attn_pkg::idx_t'(attn_pkg::LOAD_CYCLES);
        endcase
    end

    assign last = (phase != attn_pkg::IDLE) && (idx == len - 8'd1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx <= '0;
        end else if (last) begin
            idx <= '0;
        end else if (start || (phase != attn_pkg::IDLE)) begin
            idx <= idx + 8'd1;
        end
    end

endmodule

// File: attn_input_buffer.sv
//##########################################################################
// X, Wq, Wk and Wv stores, written in row-major order during the load
// X rows at or above T keep their old contents
//##########################################################################

`timescale 1ns/1ps

module attn_input_buffer (
    input  logic              clk,
    input  logic              rst_n,
    input  attn_pkg::phase_t  phase,
    input  logic              start,
    input  attn_pkg::idx_t    idx,
    input  attn_pkg::rows_t   t_rows,
    input  attn_pkg::token_t  in_data,
    input  attn_pkg::weight_t w_q,
    input  attn_pkg::weight_t w_k,
    input  attn_pkg::weight_t w_v,
    output attn_pkg::token_t  x_mem  [attn_pkg::MAT_SIZE],
    output attn_pkg::weight_t wq_mem [attn_pkg::MAT_SIZE],
    output attn_pkg::weight_t wk_mem [attn_pkg::MAT_SIZE],
    output attn_pkg::weight_t wv_mem [attn_pkg::MAT_SIZE]
);

    logic       load_en;
    logic       x_we;
    logic       q_we;
    logic       k_we;
    logic       v_we;
    logic [5:0] slot;

    assign load_en = start || (phase == attn_pkg::LOAD);
    assign slot    = idx[5:0];

    // on the start beat t_rows still holds the previous T, but idx is 0
    // there and every T gives at least one row
    assign x_we = load_en &&
                  (idx < attn_pkg::idx_t'(t_rows) * attn_pkg::idx_t'(attn_pkg::D_MODEL));

    // weight segments follow each other in the load window
    assign q_we = load_en && (idx < attn_pkg::idx_t'(attn_pkg::W_SEG));
    assign k_we = load_en && (idx >= attn_pkg::idx_t'(attn_pkg::W_SEG)) &&
                  (idx < attn_pkg::idx_t'(2 * attn_pkg::W_SEG));
    assign v_we = load_en && (idx >= attn_pkg::idx_t'(2 * attn_pkg::W_SEG));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int a = 0; a < attn_pkg::MAT_SIZE; a++) begin
                x_mem[a]  <= '0;
                wq_mem[a] <= '0;
                wk_mem[a] <= '0;
                wv_mem[a] <= '0;
            end
        end else begin
            if (x_we)
                x_mem[slot] <= in_data;
            if (q_we)
                wq_mem[slot] <= w_q;
            if (k_we)
                wk_mem[slot] <= w_k;
            if (v_we)
                wv_mem[slot] <= w_v;
        end
    end

endmodule

// File: attn_projection.sv
//##########################################################################
// Q, K and V projection, one element per cycle through 8 signed lanes
// stage 1 registers X row t and weight column j, stage 2 writes the sum
//##########################################################################

`timescale 1ns/1ps

module attn_projection (
    input  logic              clk,
    input  logic              rst_n,
    input  attn_pkg::phase_t  phase,
    input  attn_pkg::idx_t    idx,
    input  attn_pkg::token_t  x_mem  [attn_pkg::MAT_SIZE],
    input  attn_pkg::weight_t wq_mem [attn_pkg::MAT_SIZE],
    input  attn_pkg::weight_t wk_mem [attn_pkg::MAT_SIZE],
    input  attn_pkg::weight_t wv_mem [attn_pkg::MAT_SIZE],
    output attn_pkg::proj_t   q_mem  [attn_pkg::MAT_SIZE],
    output attn_pkg::proj_t   k_mem  [attn_pkg::MAT_SIZE],
    output attn_pkg::proj_t   v_mem  [attn_pkg::MAT_SIZE]
);

    logic                is_proj;
    logic [2:0]          row;
    logic [2:0]          col;
    attn_pkg::weight_t   w_sel   [attn_pkg::D_MODEL];
    attn_pkg::token_t    x_op    [attn_pkg::D_MODEL];
    attn_pkg::weight_t   w_op    [attn_pkg::D_MODEL];
    logic signed [15:0]  prod    [attn_pkg::D_MODEL];
    attn_pkg::proj_t     dot;
    attn_pkg::phase_t    phase_d;
    logic [5:0]          addr_d;

    assign is_proj = phase inside {attn_pkg::PROJ_Q, attn_pkg::PROJ_K, attn_pkg::PROJ_V};

    // step t*8+j
    assign row = idx[5:3];
    assign col = idx[2:0];

    // column j of the weight matrix of this phase
    always_comb begin
        for (int m = 0; m < attn_pkg::D_MODEL; m++) begin
            case (phase)
                attn_pkg::PROJ_K: w_sel[m] = wk_mem[{3'(m), col}];
                attn_pkg::PROJ_V: w_sel[m] = wv_mem[{3'(m), col}];
                default:          w_sel[m] = wq_mem[{3'(m), col}];
            endcase
        end
    end

    //######################################################################
    // stage 1, operand registers
    //######################################################################

    always_ff @(posedge clk) begin
        if (is_proj) begin
            for (int m = 0; m < attn_pkg::D_MODEL; m++) begin
                x_op[m] <= x_mem[{row, 3'(m)}];
                w_op[m] <= w_sel[m];
            end
            addr_d <= idx[5:0];
        end
    end

    // phase follows the operands so the write picks the right store
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase_d <= attn_pkg::IDLE;
        end else begin
            phase_d <= phase;
        end
    end

    //######################################################################
    // stage 2, lane products summed and written
    //######################################################################

    always_comb begin
        dot = '0;
        for (int m = 0; m < attn_pkg::D_MODEL; m++) begin
            prod[m] = x_op[m] * w_op[m];
            dot     = dot + attn_pkg::proj_t'(prod[m]);
        end
    end

    always_ff @(posedge clk) begin
        case (phase_d)
            attn_pkg::PROJ_Q: q_mem[addr_d] <= dot;
            attn_pkg::PROJ_K: k_mem[addr_d] <= dot;
            attn_pkg::PROJ_V: v_mem[addr_d] <= dot;
            default: ;
        endcase
    end

endmodule

// File: attn_score_output.sv
//##########################################################################
// S = relu(Q.K^T) / 3 with floor, then O = S.V streamed row-major
// S is kept 8 wide, columns at or above T are masked when O is formed
//##########################################################################

`timescale 1ns/1ps

module attn_score_output (
    input  logic             clk,
    input  logic             rst_n,
    input  attn_pkg::phase_t phase,
    input  attn_pkg::idx_t   idx,
    input  attn_pkg::rows_t  t_rows,
    input  attn_pkg::proj_t  q_mem [attn_pkg::MAT_SIZE],
    input  attn_pkg::proj_t  k_mem [attn_pkg::MAT_SIZE],
    input  attn_pkg::proj_t  v_mem [attn_pkg::MAT_SIZE],
    output logic             out_valid,
    output attn_pkg::out_t   out_data
);

    logic [2:0]                   s_row;
    logic [2:0]                   s_col;
    attn_pkg::proj_t              q_op    [attn_pkg::D_MODEL];
    attn_pkg::proj_t              k_op    [attn_pkg::D_MODEL];
    logic [5:0]                   s_addr1;
    logic [5:0]                   s_addr2;
    logic                         sc_v1;
    logic                         sc_v2;
    logic signed [attn_pkg::DOT_W-1:0] qk_sum;
    logic signed [attn_pkg::DOT_W-1:0] qk_dot;
    attn_pkg::score_t             s_val;
    attn_pkg::score_t             s_mem   [attn_pkg::MAT_SIZE];
    attn_pkg::score_t             s_op    [attn_pkg::D_MODEL];
    attn_pkg::proj_t              v_op    [attn_pkg::D_MODEL];
    logic                         ov1;
    attn_pkg::out_t               sv_sum;

    //######################################################################
    // score pipeline, step i*T+j
    //######################################################################

    always_comb begin
        case (t_rows)
            4'd1: begin
                s_row = 3'd0;
                s_col = 3'd0;
            end
            4'd4: begin
                s_row = {1'b0, idx[3:2]};
                s_col = {1'b0, idx[1:0]};
            end
            default: begin
                s_row = idx[5:3];
                s_col = idx[2:0];
            end
        endcase
    end

    // stage 1 and 2, operands then the full dot product
    always_ff @(posedge clk) begin
        for (int m = 0; m < attn_pkg::D_MODEL; m++) begin
            q_op[m] <= q_mem[{s_row, 3'(m)}];
            k_op[m] <= k_mem[{s_col, 3'(m)}];
        end
        s_addr1 <= {s_row, s_col};
        s_addr2 <= s_addr1;
        qk_dot  <= qk_sum;
    end

    // products are formed at the full sum width
    always_comb begin
        qk_sum = '0;
        for (int m = 0; m < attn_pkg::D_MODEL; m++)
            qk_sum = qk_sum + q_op[m] * k_op[m];
    end

    // stage 3, clamp at zero and floor divide
    assign s_val = qk_dot[attn_pkg::DOT_W-1] ? '0 : attn_pkg::score_t'(qk_dot / 3);

    always_ff @(posedge clk) begin
        if (sc_v2)
            s_mem[s_addr2] <= s_val;
    end

    //######################################################################
    // output pipeline, step i*8+j
    //######################################################################

    always_ff @(posedge clk) begin
        for (int m = 0; m < attn_pkg::D_MODEL; m++) begin
            s_op[m] <= (m < t_rows) ? s_mem[{idx[5:3], 3'(m)}] : '0;
            v_op[m] <= v_mem[{3'(m), idx[2:0]}];
        end
    end

    always_comb begin
        sv_sum = '0;
        for (int m = 0; m < attn_pkg::D_MODEL; m++)
            sv_sum = sv_sum + $signed({1'b0, s_op[m]}) * v_op[m];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sc_v1     <= 1'b0;
            sc_v2     <= 1'b0;
            ov1       <= 1'b0;
            out_valid <= 1'b0;
            out_data  <= '0;
        end else begin
            sc_v1     <= (phase == attn_pkg::SCORE);
            sc_v2     <= sc_v1;
            ov1       <= (phase == attn_pkg::OUT);
            out_valid <= ov1;
            // zero between beats
            out_data  <= ov1 ? sv_sum : '0;
        end
    end

endmodule

// File: attn_top.sv
//##########################################################################
// single-head attention top, no handshake on either side
// in_valid must stay high for exactly the 192-cycle load window
//##########################################################################

`timescale 1ns/1ps

module attn_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  attn_pkg::rows_t   t_in,
    input  attn_pkg::token_t  in_data,
    input  attn_pkg::weight_t w_q,
    input  attn_pkg::weight_t w_k,
    input  attn_pkg::weight_t w_v,
    output logic              out_valid,
    output attn_pkg::out_t    out_data
);

    attn_pkg::phase_t  phase;
    logic              start;
    attn_pkg::rows_t   t_rows;
    attn_pkg::idx_t    idx;
    logic              last;
    attn_pkg::token_t  x_mem  [attn_pkg::MAT_SIZE];
    attn_pkg::weight_t wq_mem [attn_pkg::MAT_SIZE];
    attn_pkg::weight_t wk_mem [attn_pkg::MAT_SIZE];
    attn_pkg::weight_t wv_mem [attn_pkg::MAT_SIZE];
    attn_pkg::proj_t   q_mem  [attn_pkg::MAT_SIZE];
    attn_pkg::proj_t   k_mem  [attn_pkg::MAT_SIZE];
    attn_pkg::proj_t   v_mem  [attn_pkg::MAT_SIZE];

    attn_ctrl u_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .t_in     (t_in),
        .last     (last),
        .phase    (phase),
        .start    (start),
        .t_rows   (t_rows)
    );

    attn_step_counter u_step (
        .clk    (clk),
        .rst_n  (rst_n),
        .phase  (phase),
        .start  (start),
        .t_rows (t_rows),
        .idx    (idx),
        .last   (last)
    );

    attn_input_buffer u_buf (
        .clk     (clk),
        .rst_n   (rst_n),
        .phase   (phase),
        .start   (start),
        .idx     (idx),
        .t_rows  (t_rows),
        .in_data (in_data),
        .w_q     (w_q),
        .w_k     (w_k),
        .w_v     (w_v),
        .x_mem   (x_mem),
        .wq_mem  (wq_mem),
        .wk_mem  (wk_mem),
        .wv_mem  (wv_mem)
    );

    attn_projection u_proj (
        .clk    (clk),
        .rst_n  (rst_n),
        .phase  (phase),
        .idx    (idx),
        .x_mem  (x_mem),
        .wq_mem (wq_mem),
        .wk_mem (wk_mem),
        .wv_mem (wv_mem),
        .q_mem  (q_mem),
        .k_mem  (k_mem),
        .v_mem  (v_mem)
    );

    attn_score_output u_score (
        .clk       (clk),
        .rst_n     (rst_n),
        .phase     (phase),
        .idx       (idx),
        .t_rows    (t_rows),
        .q_mem     (q_mem),
        .k_mem     (k_mem),
        .v_mem     (v_mem),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

// File: attn_checker.sv
//##########################################################################
// output checker, samples out_valid and out_data on the rising edge
// counts are cleared while armed is low, done rises after the last beat
//##########################################################################

`timescale 1ns/1ps

module attn_checker #(
    parameter int CLK_PERIOD = 10
) (
    input  logic           clk,
    input  logic           out_valid,
    input  attn_pkg::out_t out_data,
    input  logic           armed,
    input  int             exp_beats,
    input  int             exp_first,
    input  time            start_time,
    input  attn_pkg::out_t exp_o [attn_pkg::MAT_SIZE],
    output int             beats,
    output int             errors,
    output bit             done
);

    int cycle;

    always @(posedge clk) begin
        if (!armed) begin
            beats  = 0;
            errors = 0;
            done   = 1'b0;
        end else if (out_valid) begin
            // cycle 0 is the edge that took the first load beat
            if (beats == 0) begin
                cycle = int'(($time - start_time) / CLK_PERIOD);
                if (cycle != exp_first) begin
                    $display("ERR %0d ns out_valid first cycle expected %0d actual %0d",
                             $time, exp_first, cycle);
                    errors++;
                end
            end
            if (beats < exp_beats && out_data !== exp_o[beats]) begin
                $display("ERR %0d ns out_data beat %0d expected %0d actual %0d",
                         $time, beats, exp_o[beats], out_data);
                errors++;
            end
            beats++;
        end else if (beats > 0 && !done) begin
            // first low cycle after the stream
            done = 1'b1;
            if (beats != exp_beats) begin
                $display("ERR %0d ns out_valid beat count expected %0d actual %0d",
                         $time, exp_beats, beats);
                errors++;
            end
        end
    end

endmodule

// File: attn_properties.sv
//##########################################################################
// assertions on the output signals, bound into attn_top
//##########################################################################

`timescale 1ns/1ps

module attn_properties (
    input logic           clk,
    input logic           rst_n,
    input logic           out_valid,
    input attn_pkg::out_t out_data
);

    int fail_count = 0;

    // outputs stay quiet in reset and on the first edge after it
    reset_quiet: assert property (@(posedge clk) !rst_n |-> !out_valid && out_data == '0)
        else begin
            $error("out_valid or out_data not zero during reset");
            fail_count++;
        end

    after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !out_valid)
        else begin
            $error("out_valid high on the first edge after reset");
            fail_count++;
        end

    zero_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
                                     !out_valid |-> out_data == '0)
        else begin
            $error("out_data not zero while out_valid is low");
            fail_count++;
        end

endmodule

bind attn_top attn_properties u_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .out_valid (out_valid),
    .out_data  (out_data)
);

// File: tb_attn_top.sv
//##########################################################################
// testbench for attn_top, random runs checked against a model of the rules
// the first run uses T = 8 so that every row of the result stores is defined
//##########################################################################

`timescale 1ns/1ps

module tb_attn_top;

    localparam int CLK_PERIOD = 10;
    localparam int NUM_TESTS  = 8;
    // longest run at T = 8, plus the idle gap between runs
    localparam int RUN_MAX    = attn_pkg::LOAD_CYCLES + 32 * attn_pkg::D_MODEL +
                                attn_pkg::MAT_SIZE + 16;
    localparam int WATCHDOG_CYCLES = 8 + NUM_TESTS * RUN_MAX + 100;

    logic              clk;
    logic              rst_n;
    logic              in_valid;
    attn_pkg::rows_t   t_in;
    attn_pkg::token_t  in_data;
    attn_pkg::weight_t w_q;
    attn_pkg::weight_t w_k;
    attn_pkg::weight_t w_v;
    logic              out_valid;
    attn_pkg::out_t    out_data;

    // expected results and checker status
    logic              armed;
    int                exp_beats;
    int                exp_first;
    time               start_time;
    attn_pkg::out_t    exp_o [attn_pkg::MAT_SIZE];
    longint            raw_o [attn_pkg::MAT_SIZE];
    int                beats;
    int                chk_errors;
    bit                done;

    // operands of the current run, row-major
    attn_pkg::token_t  x_m  [attn_pkg::D_MODEL][attn_pkg::D_MODEL];
    attn_pkg::weight_t wq_m [attn_pkg::D_MODEL][attn_pkg::D_MODEL];
    attn_pkg::weight_t wk_m [attn_pkg::D_MODEL][attn_pkg::D_MODEL];
    attn_pkg::weight_t wv_m [attn_pkg::D_MODEL][attn_pkg::D_MODEL];

    int                seed;
    int                test_num;
    int                tests_failed;
    int                total_errors;

    attn_top uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .t_in      (t_in),
        .in_data   (in_data),
        .w_q       (w_q),
        .w_k       (w_k),
        .w_v       (w_v),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    attn_checker #(.CLK_PERIOD(CLK_PERIOD)) u_checker (
        .clk        (clk),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .armed      (armed),
        .exp_beats  (exp_beats),
        .exp_first  (exp_first),
        .start_time (start_time),
        .exp_o      (exp_o),
        .beats      (beats),
        .errors     (chk_errors),
        .done       (done)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    //######################################################################
    // operands and reference model
    //######################################################################

    // opposed_keys negates the first four key columns, which drives
    // many Q.K sums far below zero
    task automatic fill_operands(input bit opposed_keys);
        for (int i = 0; i < attn_pkg::D_MODEL; i++) begin
            for (int j = 0; j < attn_pkg::D_MODEL; j++) begin
                x_m[i][j]  = attn_pkg::token_t'($random(seed));
                wv_m[i][j] = attn_pkg::weight_t'($random(seed));
                if (opposed_keys) begin
                    wq_m[i][j] = attn_pkg::weight_t'($random(seed) % 100);
                    wk_m[i][j] = (j < 4) ? -wq_m[i][j] : wq_m[i][j];
                end else begin
                    wq_m[i][j] = attn_pkg::weight_t'($random(seed));
                    wk_m[i][j] = attn_pkg::weight_t'($random(seed));
                end
            end
        end
    endtask

    task automatic build_expected(input int t_eff);
        longint qm    [8][8];
        longint km    [8][8];
        longint vm    [8][8];
        longint s_cl  [8][8];
        longint s_raw [8][8];
        longint dot;
        longint o_cl;
        longint o_nc;
        for (int i = 0; i < t_eff; i++) begin
            for (int j = 0; j < attn_pkg::D_MODEL; j++) begin
                qm[i][j] = 0;
                km[i][j] = 0;
                vm[i][j] = 0;
                for (int m = 0; m < attn_pkg::D_MODEL; m++) begin
                    qm[i][j] += longint'(x_m[i][m]) * longint'(wq_m[m][j]);
                    km[i][j] += longint'(x_m[i][m]) * longint'(wk_m[m][j]);
                    vm[i][j] += longint'(x_m[i][m]) * longint'(wv_m[m][j]);
                end
            end
        end
        for (int i = 0; i < t_eff; i++) begin
            for (int j = 0; j < t_eff; j++) begin
                dot = 0;
                for (int m = 0; m < attn_pkg::D_MODEL; m++)
                    dot += qm[i][m] * km[j][m];
                s_cl[i][j]  = (dot < 0) ? 0 : dot / 3;
                s_raw[i][j] = dot / 3;
            end
        end
        for (int a = 0; a < attn_pkg::MAT_SIZE; a++) begin
            exp_o[a] = '0;
            raw_o[a] = 0;
        end
        for (int i = 0; i < t_eff; i++) begin
            for (int j = 0; j < attn_pkg::D_MODEL; j++) begin
                o_cl = 0;
                o_nc = 0;
                for (int m = 0; m < t_eff; m++) begin
                    o_cl += s_cl[i][m] * vm[m][j];
                    o_nc += s_raw[i][m] * vm[m][j];
                end
                exp_o[i * 8 + j] = attn_pkg::out_t'(o_cl);
                raw_o[i * 8 + j] = o_nc;
            end
        end
    endtask

    //######################################################################
    // stimulus
    //######################################################################

    task automatic drive_load(input int t_drive);
        for (int k = 0; k < attn_pkg::LOAD_CYCLES; k++) begin
            @(negedge clk);
            if (k == 0) begin
                start_time = $time + CLK_PERIOD / 2;
                armed      = 1'b1;
            end
            in_valid = 1'b1;
            t_in     = attn_pkg::rows_t'(t_drive);
            in_data  = (k < 64) ? x_m[k / 8][k % 8] : attn_pkg::token_t'($random(seed));
            w_q      = (k < 64) ? wq_m[k / 8][k % 8] : attn_pkg::weight_t'($random(seed));
            w_k      = (k >= 64 && k < 128) ? wk_m[(k - 64) / 8][k % 8]
                                            : attn_pkg::weight_t'($random(seed));
            w_v      = (k >= 128) ? wv_m[(k - 128) / 8][k % 8]
                                  : attn_pkg::weight_t'($random(seed));
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    // stray in_valid beats with garbage while the projections run
    task automatic pulse_during_compute();
        for (int p = 0; p < 16; p++) begin
            @(negedge clk);
            in_valid = (p % 2 == 0);
            t_in     = attn_pkg::rows_t'($random(seed));
            in_data  = attn_pkg::token_t'($random(seed));
            w_q      = attn_pkg::weight_t'($random(seed));
            w_k      = attn_pkg::weight_t'($random(seed));
            w_v      = attn_pkg::weight_t'($random(seed));
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic run_test(input string name, input int t_drive, input bit pulses,
                            input bit check_clamp);
        int t_eff;
        bit failed;
        bit differs;
        t_eff   = (t_drive == 1 || t_drive == 4) ? t_drive : attn_pkg::D_MODEL;
        failed  = 1'b0;
        differs = 1'b0;
        build_expected(t_eff);
        exp_beats = 8 * t_eff;
        exp_first = attn_pkg::LOAD_CYCLES + 24 * t_eff + t_eff * t_eff + 4;
        if (check_clamp) begin
            for (int a = 0; a < exp_beats; a++)
                differs |= (longint'(exp_o[a]) != raw_o[a]);
            if (!differs) begin
                $display("clamp run has no negative score that changes the output");
                failed = 1'b1;
            end
        end
        drive_load(t_drive);
        if (pulses)
            pulse_during_compute();
        while (!done)
            @(negedge clk);
        failed |= (chk_errors != 0);
        test_num++;
        total_errors += chk_errors;
        if (failed)
            tests_failed++;
        $display("test %0d %s (t_in=%0d): %0d beats, %0d errors, %s", test_num, name,
                 t_drive, beats, chk_errors, failed ? "FAIL" : "ok");
        armed = 1'b0;
    endtask

    //######################################################################
    // main sequence and watchdog
    //######################################################################

    initial begin
        seed         = 54274;
        test_num     = 0;
        tests_failed = 0;
        total_errors = 0;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        t_in         = '0;
        in_data      = '0;
        w_q          = '0;
        w_k          = '0;
        w_v          = '0;
        armed        = 1'b0;
        exp_beats    = 0;
        exp_first    = 0;
        start_time   = 0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        fill_operands(1'b0);
        run_test("random_t8", 8, 1'b0, 1'b0);
        fill_operands(1'b0);
        run_test("random_t1", 1, 1'b0, 1'b0);
        fill_operands(1'b0);
        run_test("random_t4", 4, 1'b0, 1'b0);
        fill_operands(1'b0);
        run_test("t_in_0_runs_as_8", 0, 1'b0, 1'b0);
        fill_operands(1'b0);
        run_test("t_in_2_runs_as_8", 2, 1'b0, 1'b0);
        fill_operands(1'b0);
        run_test("t_in_15_runs_as_8", 15, 1'b0, 1'b0);
        fill_operands(1'b1);
        run_test("negative_scores", 8, 1'b0, 1'b1);
        fill_operands(1'b0);
        run_test("in_valid_ignored", 4, 1'b1, 1'b0);

        $display("summary: %0d tests, %0d failed, %0d check errors, %0d assertion failures",
                 test_num, tests_failed, total_errors, uut.u_props.fail_count);
        if (tests_failed == 0 && uut.u_props.fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the runs did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("sim failed");
        $finish;
    end

endmodule

// File: attn_top.f
attn_pkg.sv
attn_ctrl.sv
attn_step_counter.sv
attn_input_buffer.sv
attn_projection.sv
attn_score_output.sv
attn_top.sv
attn_checker.sv
attn_properties.sv
tb_attn_top.sv

// File: Bender.yml
package:
  name: attn_top

sources:
  - attn_pkg.sv
  - attn_ctrl.sv
  - attn_step_counter.sv
  - attn_input_buffer.sv
  - attn_projection.sv
  - attn_score_output.sv
  - attn_top.sv
  - target: simulation
    files:
      - attn_checker.sv
      - attn_properties.sv
      - tb_attn_top.sv
